// File: iew_core.f
+incdir+tests
logic/core_cfg_pkg.sv
logic/uop_pkg.sv
logic/regfile.sv
logic/scoreboard.sv
logic/issue_stage.sv
logic/reorder_buffer.sv
logic/commit_stage.sv
logic/iew_core.sv
tests/iew_core_tb.sv

// File: logic/commit_stage.sv
`timescale 1ns/1ns
`default_nettype none

module commit_stage (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire uop_pkg::rob_entry_t head_i,
    input  wire logic                head_valid_i,
    output logic                     pop_o,
    output uop_pkg::preg_id_t        prf_raddr_o,
    input  wire uop_pkg::xlen_t      prf_rdata_i,
    output logic                     arf_we_o,
    output uop_pkg::areg_id_t        arf_waddr_o,
    output uop_pkg::xlen_t           arf_wdata_o,
    output uop_pkg::rob_entry_t      retire_o,
    output logic                     retire_valid_o
);

    uop_pkg::rob_entry_t entry_q;
    uop_pkg::xlen_t      rdval_q;
    logic                valid_q;

    // Retire: pop whenever the head is done
    assign pop_o       = head_valid_i;
    assign prf_raddr_o = head_i.prd;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= head_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        entry_q <= head_i;
        rdval_q <= prf_rdata_i;
    end

    // Commit: architectural update
    assign retire_o       = entry_q;
    assign retire_valid_o = valid_q;
    assign arf_we_o       = valid_q && entry_q.need_arf_write;
    assign arf_waddr_o    = entry_q.ard;
    assign arf_wdata_o    = rdval_q;

endmodule

`default_nettype wire

// File: logic/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

    // Datapath width
    localparam int XLEN = 32;

    // Register files
    localparam int NR_PREGS     = 32;
    localparam int NR_AREGS     = 16;
    localparam int PREG_ID_BITS = 5;
    localparam int AREG_ID_BITS = 4;

    // Reorder buffer
    localparam int NR_ROB_ENTRIES = 8;
    localparam int ROB_ID_BITS    = 3;

    // Result and completion ports, functional units
    localparam int NR_WB_PORTS    = 2;
    localparam int NR_COMPL_PORTS = 2;
    localparam int NR_FUS         = 3;

endpackage

`default_nettype wire

// File: logic/iew_core.sv
`timescale 1ns/1ns
`default_nettype none

module iew_core (
    input  wire logic                                                  clk,
    input  wire logic                                                  rstn,
    input  wire uop_pkg::renamed_inst_t                                di_i,
    input  wire logic                                                  di_valid_i,
    output logic                                                       di_ready_o,
    output uop_pkg::fu_input_t                                         fu_input_o,
    output logic                                                       fu_valid_o,
    input  wire logic [core_cfg_pkg::NR_FUS-1:0]                       fu_ready_i,
    input  wire uop_pkg::fu_output_t [core_cfg_pkg::NR_WB_PORTS-1:0]   bypass_i,
    input  wire logic [core_cfg_pkg::NR_WB_PORTS-1:0]                  bypass_valid_i,
    input  wire uop_pkg::fu_output_t [core_cfg_pkg::NR_WB_PORTS-1:0]   wb_i,
    input  wire logic [core_cfg_pkg::NR_WB_PORTS-1:0]                  wb_valid_i,
    input  wire uop_pkg::completion_t [core_cfg_pkg::NR_COMPL_PORTS-1:0] compl_i,
    output uop_pkg::rob_entry_t                                        retire_o,
    output logic                                                       retire_valid_o
);

    // PRF: ports 0 and 1 for issue, port 2 for retire
    uop_pkg::preg_id_t [2:0]                         prf_raddr;
    uop_pkg::xlen_t    [2:0]                         prf_rdata;
    uop_pkg::preg_id_t [core_cfg_pkg::NR_WB_PORTS-1:0] prf_waddr;
    uop_pkg::xlen_t    [core_cfg_pkg::NR_WB_PORTS-1:0] prf_wdata;

    uop_pkg::areg_id_t [1:0] arf_raddr;
    uop_pkg::xlen_t    [1:0] arf_rdata;
    logic              [0:0] arf_we;
    uop_pkg::areg_id_t [0:0] arf_waddr;
    uop_pkg::xlen_t    [0:0] arf_wdata;

    uop_pkg::preg_id_t [1:0] sb_raddr;
    logic              [1:0] sb_ready;
    logic                    sb_clr;
    uop_pkg::preg_id_t       sb_clr_addr;

    logic                rob_push;
    uop_pkg::rob_entry_t rob_entry;
    logic                rob_full;
    uop_pkg::rob_entry_t rob_head;
    logic                rob_head_valid;
    logic                rob_pop;

    always_comb begin
        for (int i = 0; i < core_cfg_pkg::NR_WB_PORTS; i++) begin
            prf_waddr[i] = wb_i[i].prd;
            prf_wdata[i] = wb_i[i].rdval;
        end
    end

    issue_stage issue_i (
        .di_i(di_i), .di_valid_i(di_valid_i), .di_ready_o(di_ready_o),
        .fu_ready_i(fu_ready_i), .bypass_i(bypass_i), .bypass_valid_i(bypass_valid_i),
        .prf_raddr_o(prf_raddr[1:0]), .prf_rdata_i(prf_rdata[1:0]),
        .arf_raddr_o(arf_raddr), .arf_rdata_i(arf_rdata),
        .sb_raddr_o(sb_raddr), .sb_ready_i(sb_ready),
        .sb_clr_o(sb_clr), .sb_clr_addr_o(sb_clr_addr),
        .rob_push_o(rob_push), .rob_entry_o(rob_entry), .rob_full_i(rob_full),
        .fu_input_o(fu_input_o), .fu_valid_o(fu_valid_o)
    );

    scoreboard #(
        .NREGS(core_cfg_pkg::NR_PREGS), .NSET(core_cfg_pkg::NR_WB_PORTS), .NREAD(2)
    ) sb_i (
        .clk(clk), .rstn(rstn), .set_i(wb_valid_i), .set_addr_i(prf_waddr),
        .clr_i(sb_clr), .clr_addr_i(sb_clr_addr), .raddr_i(sb_raddr), .ready_o(sb_ready)
    );

    regfile #(
        .WIDTH(core_cfg_pkg::XLEN), .NREGS(core_cfg_pkg::NR_PREGS),
        .NREAD(3), .NWRITE(core_cfg_pkg::NR_WB_PORTS)
    ) prf_i (
        .clk(clk), .rstn(rstn), .we_i(wb_valid_i), .waddr_i(prf_waddr),
        .wdata_i(prf_wdata), .raddr_i(prf_raddr), .rdata_o(prf_rdata)
    );

    regfile #(
        .WIDTH(core_cfg_pkg::XLEN), .NREGS(core_cfg_pkg::NR_AREGS), .NREAD(2), .NWRITE(1)
    ) arf_i (
        .clk(clk), .rstn(rstn), .we_i(arf_we), .waddr_i(arf_waddr),
        .wdata_i(arf_wdata), .raddr_i(arf_raddr), .rdata_o(arf_rdata)
    );

    reorder_buffer #(
        .DEPTH(core_cfg_pkg::NR_ROB_ENTRIES)
    ) rob_i (
        .clk(clk), .rstn(rstn), .push_i(rob_push), .push_entry_i(rob_entry),
        .full_o(rob_full), .compl_i(compl_i), .head_o(rob_head),
        .head_valid_o(rob_head_valid), .pop_i(rob_pop)
    );

    commit_stage commit_i (
        .clk(clk), .rstn(rstn), .head_i(rob_head), .head_valid_i(rob_head_valid),
        .pop_o(rob_pop), .prf_raddr_o(prf_raddr[2]), .prf_rdata_i(prf_rdata[2]),
        .arf_we_o(arf_we[0]), .arf_waddr_o(arf_waddr[0]), .arf_wdata_o(arf_wdata[0]),
        .retire_o(retire_o), .retire_valid_o(retire_valid_o)
    );

endmodule

`default_nettype wire

// File: logic/issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

module issue_stage (
    input  wire uop_pkg::renamed_inst_t                             di_i,
    input  wire logic                                               di_valid_i,
    output logic                                                    di_ready_o,
    input  wire logic [core_cfg_pkg::NR_FUS-1:0]                    fu_ready_i,
    input  wire uop_pkg::fu_output_t [core_cfg_pkg::NR_WB_PORTS-1:0] bypass_i,
    input  wire logic [core_cfg_pkg::NR_WB_PORTS-1:0]               bypass_valid_i,
    output uop_pkg::preg_id_t [1:0]                                 prf_raddr_o,
    input  wire uop_pkg::xlen_t [1:0]                               prf_rdata_i,
    output uop_pkg::areg_id_t [1:0]                                 arf_raddr_o,
    input  wire uop_pkg::xlen_t [1:0]                               arf_rdata_i,
    output uop_pkg::preg_id_t [1:0]                                 sb_raddr_o,
    input  wire logic [1:0]                                         sb_ready_i,
    output logic                                                    sb_clr_o,
    output uop_pkg::preg_id_t                                       sb_clr_addr_o,
    output logic                                                    rob_push_o,
    output uop_pkg::rob_entry_t                                     rob_entry_o,
    input  wire logic                                               rob_full_i,
    output uop_pkg::fu_input_t                                      fu_input_o,
    output logic                                                    fu_valid_o
);

    uop_pkg::preg_id_t [1:0] prs;
    logic [1:0]              renamed;
    uop_pkg::xlen_t [1:0]    src_val;
    logic [1:0]              src_rdy;
    uop_pkg::xlen_t          rs1val;
    uop_pkg::xlen_t          rs2val;
    logic                    rs1_rdy;
    logic                    rs2_rdy;
    logic                    fu_ok;
    logic                    nostall;

    assign prs         = {di_i.prs2, di_i.prs1};
    assign renamed     = {di_i.prs2_renamed, di_i.prs1_renamed};
    assign prf_raddr_o = prs;
    assign sb_raddr_o  = prs;
    assign arf_raddr_o = {di_i.si.rs2, di_i.si.rs1};

    // Renamed source: bypass over PRF, PRF gated by scoreboard
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (renamed[i]) begin
                src_val[i] = prf_rdata_i[i];
                src_rdy[i] = sb_ready_i[i];
                for (int j = 0; j < core_cfg_pkg::NR_WB_PORTS; j++) begin
                    if (bypass_valid_i[j] && bypass_i[j].prd == prs[i]) begin
                        src_val[i] = bypass_i[j].rdval;
                        src_rdy[i] = 1'b1;
                    end
                end
            end else begin
                // ARF holds committed state, never busy
                src_val[i] = arf_rdata_i[i];
                src_rdy[i] = 1'b1;
            end
        end
    end

    always_comb begin
        rs1val  = '0;
        rs1_rdy = 1'b1;
        if (di_i.si.op == uop_pkg::AUIPC) begin
            rs1val = di_i.si.pc;
        end else if (di_i.si.use_uimm) begin
            rs1val = uop_pkg::xlen_t'(di_i.si.rs1);
        end else if (di_i.si.rs1_valid) begin
            rs1val  = src_val[0];
            rs1_rdy = src_rdy[0];
        end
        if (di_i.si.rs2_valid) begin
            rs2val  = src_val[1];
            rs2_rdy = src_rdy[1];
        end else begin
            rs2val  = di_i.si.imm;
            rs2_rdy = 1'b1;
        end
    end

    assign fu_ok = (int'(di_i.si.fu) < core_cfg_pkg::NR_FUS) && fu_ready_i[di_i.si.fu];

    assign nostall    = !di_valid_i || (rs1_rdy && rs2_rdy && fu_ok && !rob_full_i);
    assign di_ready_o = nostall;
    assign fu_valid_o = di_valid_i && nostall;

    assign fu_input_o.pc     = di_i.si.pc;
    assign fu_input_o.id     = di_i.id;
    assign fu_input_o.prd    = di_i.prd;
    assign fu_input_o.rs1val = rs1val;
    assign fu_input_o.rs2val = rs2val;
    assign fu_input_o.imm    = di_i.si.imm;
    assign fu_input_o.fu     = di_i.si.fu;
    assign fu_input_o.op     = di_i.si.op;

    // ROB allocation at issue
    assign rob_push_o                 = fu_valid_o;
    assign rob_entry_o.id             = di_i.id;
    assign rob_entry_o.pc             = di_i.si.pc;
    assign rob_entry_o.prd            = di_i.prd;
    assign rob_entry_o.ard            = di_i.si.rd;
    assign rob_entry_o.need_arf_write = di_i.si.rd_valid;
    assign rob_entry_o.completed      = 1'b0;

    // Destination busy until its writeback
    assign sb_clr_o      = fu_valid_o && di_i.si.rd_valid;
    assign sb_clr_addr_o = di_i.prd;

endmodule

`default_nettype wire

// File: logic/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile #(
    parameter int WIDTH  = 32,
    parameter int NREGS  = 32,
    parameter int NREAD  = 2,
    parameter int NWRITE = 1,
    localparam int AW    = $clog2(NREGS)
) (
    input  wire logic                          clk,
    input  wire logic                          rstn,
    input  wire logic [NWRITE-1:0]             we_i,
    input  wire logic [NWRITE-1:0][AW-1:0]     waddr_i,
    input  wire logic [NWRITE-1:0][WIDTH-1:0]  wdata_i,
    input  wire logic [NREAD-1:0][AW-1:0]      raddr_i,
    output logic      [NREAD-1:0][WIDTH-1:0]   rdata_o
);

    logic [NREGS-1:0][WIDTH-1:0] regs;

    // Later ports overwrite earlier ones on an address clash
    always_ff @(posedge clk) begin
        if (!rstn) begin
            regs <= '0;
        end else begin
            for (int w = 0; w < NWRITE; w++) begin
                if (we_i[w]) begin
                    regs[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < NREAD; r++) begin
            rdata_o[r] = regs[raddr_i[r]];
        end
    end

endmodule

`default_nettype wire

// File: logic/reorder_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer #(
    parameter int DEPTH = 8,
    localparam int PW   = $clog2(DEPTH)
) (
    input  wire logic                                                  clk,
    input  wire logic                                                  rstn,
    input  wire logic                                                  push_i,
    input  wire uop_pkg::rob_entry_t                                   push_entry_i,
    output logic                                                       full_o,
    input  wire uop_pkg::completion_t [core_cfg_pkg::NR_COMPL_PORTS-1:0] compl_i,
    output uop_pkg::rob_entry_t                                        head_o,
    output logic                                                       head_valid_o,
    input  wire logic                                                  pop_i
);

    uop_pkg::rob_entry_t [DEPTH-1:0] entries;
    logic [DEPTH-1:0]                allocated;
    logic [PW-1:0]                   tail;
    logic [PW-1:0]                   head;

    // Control state
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tail      <= '0;
            head      <= '0;
            allocated <= '0;
        end else begin
            if (push_i) begin
                allocated[tail] <= 1'b1;
                tail            <= tail + 1'b1;
            end
            if (pop_i) begin
                allocated[head] <= 1'b0;
                head            <= head + 1'b1;
            end
        end
    end

    // Entry payload, completed cleared on push
    always_ff @(posedge clk) begin
        if (push_i) begin
            entries[tail]           <= push_entry_i;
            entries[tail].completed <= 1'b0;
        end
        for (int c = 0; c < core_cfg_pkg::NR_COMPL_PORTS; c++) begin
            if (compl_i[c].valid) begin
                entries[compl_i[c].id].completed <= 1'b1;
            end
        end
    end

    assign full_o       = allocated[tail];
    assign head_o       = entries[head];
    assign head_valid_o = allocated[head] && entries[head].completed;

endmodule

`default_nettype wire

// File: logic/scoreboard.sv
`timescale 1ns/1ns
`default_nettype none

module scoreboard #(
    parameter int NREGS = 32,
    parameter int NSET  = 2,
    parameter int NREAD = 2,
    localparam int AW   = $clog2(NREGS)
) (
    input  wire logic                      clk,
    input  wire logic                      rstn,
    input  wire logic [NSET-1:0]           set_i,
    input  wire logic [NSET-1:0][AW-1:0]   set_addr_i,
    input  wire logic                      clr_i,
    input  wire logic [AW-1:0]             clr_addr_i,
    input  wire logic [NREAD-1:0][AW-1:0]  raddr_i,
    output logic      [NREAD-1:0]          ready_o
);

    logic [NREGS-1:0] ready_q;
    logic [NREGS-1:0] ready_d;

    always_comb begin
        ready_d = ready_q;
        for (int s = 0; s < NSET; s++) begin
            if (set_i[s]) begin
                ready_d[set_addr_i[s]] = 1'b1;
            end
        end
        // Issue clear applied last so it takes priority
        if (clr_i) begin
            ready_d[clr_addr_i] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ready_q <= '0;
        end else begin
            ready_q <= ready_d;
        end
    end

    // Same-cycle writeback counts as ready
    always_comb begin
        for (int r = 0; r < NREAD; r++) begin
            ready_o[r] = ready_q[raddr_i[r]];
            for (int s = 0; s < NSET; s++) begin
                if (set_i[s] && set_addr_i[s] == raddr_i[r]) begin
                    ready_o[r] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/uop_pkg.sv
`default_nettype none

package uop_pkg;

    typedef logic [core_cfg_pkg::XLEN-1:0]         xlen_t;
    typedef logic [core_cfg_pkg::PREG_ID_BITS-1:0] preg_id_t;
    typedef logic [core_cfg_pkg::AREG_ID_BITS-1:0] areg_id_t;
    typedef logic [core_cfg_pkg::ROB_ID_BITS-1:0]  rob_id_t;

    // Also the bit index into fu_ready
    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_LSU  = 2'd1,
        FU_CTRL = 2'd2
    } fu_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SLT,
        LUI, AUIPC, LOAD, STORE, BRANCH, JAL, JALR
    } op_e;

    typedef struct packed {
        xlen_t    pc;
        xlen_t    imm;
        fu_e      fu;
        op_e      op;
        areg_id_t rs1;
        areg_id_t rs2;
        areg_id_t rd;
        logic     rs1_valid;
        logic     rs2_valid;
        logic     rd_valid;
        logic     use_uimm;
    } static_inst_t;

    typedef struct packed {
        static_inst_t si;
        rob_id_t      id;
        preg_id_t     prs1;
        preg_id_t     prs2;
        preg_id_t     prd;
        logic         prs1_renamed;
        logic         prs2_renamed;
    } renamed_inst_t;

    typedef struct packed {
        xlen_t    pc;
        rob_id_t  id;
        preg_id_t prd;
        xlen_t    rs1val;
        xlen_t    rs2val;
        xlen_t    imm;
        fu_e      fu;
        op_e      op;
    } fu_input_t;

    typedef struct packed {
        xlen_t    pc;
        rob_id_t  id;
        preg_id_t prd;
        xlen_t    rdval;
    } fu_output_t;

    typedef struct packed {
        rob_id_t  id;
        xlen_t    pc;
        preg_id_t prd;
        areg_id_t ard;
        logic     need_arf_write;
        logic     completed;
    } rob_entry_t;

    typedef struct packed {
        logic    valid;
        rob_id_t id;
    } completion_t;

endpackage

`default_nettype wire

// File: tests/iew_core_model.svh
`ifndef IEW_CORE_MODEL_SVH
`define IEW_CORE_MODEL_SVH

// Mirror of DUT state, advanced once per rising edge
uop_pkg::xlen_t      m_prf [core_cfg_pkg::NR_PREGS];
uop_pkg::xlen_t      m_arf [core_cfg_pkg::NR_AREGS];
logic                m_ready [core_cfg_pkg::NR_PREGS];
uop_pkg::rob_entry_t m_rob [core_cfg_pkg::NR_ROB_ENTRIES];
logic                m_alloc [core_cfg_pkg::NR_ROB_ENTRIES];
int                  m_head;
int                  m_tail;
logic                m_ret_valid;
uop_pkg::rob_entry_t m_ret_entry;
uop_pkg::xlen_t      m_ret_val;

function automatic void model_reset();
    foreach (m_prf[i]) begin
        m_prf[i]   = '0;
        m_ready[i] = 1'b0;
    end
    foreach (m_arf[i]) begin
        m_arf[i] = '0;
    end
    foreach (m_rob[i]) begin
        m_rob[i]   = '0;
        m_alloc[i] = 1'b0;
    end
    m_head      = 0;
    m_tail      = 0;
    m_ret_valid = 1'b0;
    m_ret_entry = '0;
    m_ret_val   = '0;
endfunction

// Value and readiness of one source register
function automatic void source_value(input logic renamed, input uop_pkg::preg_id_t prs,
                                     input uop_pkg::areg_id_t ars,
                                     output uop_pkg::xlen_t val, output logic rdy);
    if (!renamed) begin
        val = m_arf[ars];
        rdy = 1'b1;
    end else begin
        val = m_prf[prs];
        rdy = m_ready[prs];
        for (int p = 0; p < core_cfg_pkg::NR_WB_PORTS; p++) begin
            if (wb_valid[p] && wb[p].prd == prs) begin
                rdy = 1'b1;
            end
            if (bypass_valid[p] && bypass[p].prd == prs) begin
                val = bypass[p].rdval;
                rdy = 1'b1;
            end
        end
    end
endfunction

// Expected operands and di_ready_o for the instruction on di
function automatic void predict_issue(output uop_pkg::xlen_t rs1, output uop_pkg::xlen_t rs2,
                                      output logic ready);
    uop_pkg::xlen_t v1;
    uop_pkg::xlen_t v2;
    logic           r1;
    logic           r2;
    logic           ok1;
    logic           ok2;
    source_value(di.prs1_renamed, di.prs1, di.si.rs1, v1, r1);
    source_value(di.prs2_renamed, di.prs2, di.si.rs2, v2, r2);
    rs1 = '0;
    ok1 = 1'b1;
    if (di.si.op == uop_pkg::AUIPC) begin
        rs1 = di.si.pc;
    end else if (di.si.use_uimm) begin
        rs1[core_cfg_pkg::AREG_ID_BITS-1:0] = di.si.rs1;
    end else if (di.si.rs1_valid) begin
        rs1 = v1;
        ok1 = r1;
    end
    rs2   = di.si.rs2_valid ? v2 : di.si.imm;
    ok2   = !di.si.rs2_valid || r2;
    ready = !di_valid || (ok1 && ok2 && fu_ready[di.si.fu] && !m_alloc[m_tail]);
endfunction

task automatic model_step(input logic issued);
    logic                pop;
    uop_pkg::rob_entry_t head;
    pop  = m_alloc[m_head] && m_rob[m_head].completed;
    head = m_rob[m_head];
    // Commit writes what the retire register held during this cycle
    if (m_ret_valid && m_ret_entry.need_arf_write) begin
        m_arf[m_ret_entry.ard] = m_ret_val;
    end
    m_ret_valid = pop;
    m_ret_entry = head;
    m_ret_val   = m_prf[head.prd];
    for (int p = 0; p < core_cfg_pkg::NR_WB_PORTS; p++) begin
        if (wb_valid[p]) begin
            m_prf[wb[p].prd]   = wb[p].rdval;
            m_ready[wb[p].prd] = 1'b1;
        end
    end
    if (issued && di.si.rd_valid) begin
        m_ready[di.prd] = 1'b0;
    end
    for (int c = 0; c < core_cfg_pkg::NR_COMPL_PORTS; c++) begin
        if (compl[c].valid) begin
            m_rob[compl[c].id].completed = 1'b1;
        end
    end
    if (pop) begin
        m_alloc[m_head] = 1'b0;
        m_head          = (m_head + 1) % core_cfg_pkg::NR_ROB_ENTRIES;
    end
    if (issued) begin
        m_rob[m_tail] = '{id: di.id, pc: di.si.pc, prd: di.prd, ard: di.si.rd,
                          need_arf_write: di.si.rd_valid, completed: 1'b0};
        m_alloc[m_tail] = 1'b1;
        m_tail          = (m_tail + 1) % core_cfg_pkg::NR_ROB_ENTRIES;
    end
endtask

`endif

// File: tests/iew_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module iew_core_tb;

    localparam int NUM_CYCLES  = 2000;
    localparam int STALL_LIMIT = 64;
    localparam int DRAIN_LIMIT = 200;
    localparam int NROB        = core_cfg_pkg::NR_ROB_ENTRIES;
    localparam int NPREG       = core_cfg_pkg::NR_PREGS;

    logic                                                  clk = 1'b0;
    logic                                                  rstn;
    uop_pkg::renamed_inst_t                                di;
    logic                                                  di_valid;
    logic                                                  di_ready;
    uop_pkg::fu_input_t                                    fu_input;
    logic                                                  fu_valid;
    logic [core_cfg_pkg::NR_FUS-1:0]                       fu_ready;
    uop_pkg::fu_output_t [core_cfg_pkg::NR_WB_PORTS-1:0]   bypass;
    logic [core_cfg_pkg::NR_WB_PORTS-1:0]                  bypass_valid;
    uop_pkg::fu_output_t [core_cfg_pkg::NR_WB_PORTS-1:0]   wb;
    logic [core_cfg_pkg::NR_WB_PORTS-1:0]                  wb_valid;
    uop_pkg::completion_t [core_cfg_pkg::NR_COMPL_PORTS-1:0] compl;
    uop_pkg::rob_entry_t                                   retire;
    logic                                                  retire_valid;

    integer seed = 32'hb7de_390c;

    // Stimulus stage per ROB slot (1 issued, 2 written back, 3 completed)
    logic [1:0]        slot_state [NROB];
    uop_pkg::xlen_t    slot_val [NROB];
    logic              holding;
    int                stall_cnt;
    uop_pkg::preg_id_t last_prd;
    uop_pkg::xlen_t    exp_rs1;
    uop_pkg::xlen_t    exp_rs2;
    logic              exp_ready;
    uop_pkg::fu_input_t exp_fu;
    int                errors;
    int                timeouts;
    int                issued_cnt;
    int                retired_cnt;
    logic              aborted;

    `include "iew_core_model.svh"

    iew_core dut_i (
        .clk(clk), .rstn(rstn), .di_i(di), .di_valid_i(di_valid), .di_ready_o(di_ready),
        .fu_input_o(fu_input), .fu_valid_o(fu_valid), .fu_ready_i(fu_ready),
        .bypass_i(bypass), .bypass_valid_i(bypass_valid), .wb_i(wb), .wb_valid_i(wb_valid),
        .compl_i(compl), .retire_o(retire), .retire_valid_o(retire_valid)
    );

    always #4 clk = ~clk;

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic int find_slot(input logic [1:0] want);
        int start;
        start = rand_below(NROB);
        for (int k = 0; k < NROB; k++) begin
            if (m_alloc[(start + k) % NROB] && slot_state[(start + k) % NROB] == want) begin
                return (start + k) % NROB;
            end
        end
        return -1;
    endfunction

    function automatic logic prd_in_use(input uop_pkg::preg_id_t p);
        for (int s = 0; s < NROB; s++) begin
            if (m_alloc[s] && m_rob[s].prd == p) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Ready now, or certain to be written back later
    function automatic logic usable(input uop_pkg::preg_id_t p);
        for (int s = 0; s < NROB; s++) begin
            if (m_alloc[s] && slot_state[s] == 2'd1 && m_rob[s].prd == p) begin
                return 1'b1;
            end
        end
        return m_ready[p];
    endfunction

    task automatic pick_source(output logic renamed, output uop_pkg::preg_id_t prs);
        int start;
        renamed = 1'b0;
        prs     = uop_pkg::preg_id_t'(rand_below(NPREG));
        start   = rand_below(NPREG);
        if (rand_below(2) == 0) begin
            return;
        end
        // Favour the latest destination to hit scoreboard stalls
        if (rand_below(2) == 0 && usable(last_prd)) begin
            renamed = 1'b1;
            prs     = last_prd;
            return;
        end
        for (int k = 0; k < NPREG; k++) begin
            if (usable(uop_pkg::preg_id_t'(start + k))) begin
                renamed = 1'b1;
                prs     = uop_pkg::preg_id_t'(start + k);
                return;
            end
        end
    endtask

    task automatic new_inst(output uop_pkg::renamed_inst_t inst);
        int start;
        inst              = '0;
        inst.si.pc        = $random(seed);
        inst.si.imm       = $random(seed);
        inst.si.fu        = uop_pkg::fu_e'(rand_below(3));
        inst.si.op        = uop_pkg::op_e'(rand_below(15));
        inst.si.rs1       = uop_pkg::areg_id_t'(rand_below(core_cfg_pkg::NR_AREGS));
        inst.si.rs2       = uop_pkg::areg_id_t'(rand_below(core_cfg_pkg::NR_AREGS));
        inst.si.rd        = uop_pkg::areg_id_t'(rand_below(core_cfg_pkg::NR_AREGS));
        inst.si.rs1_valid = rand_below(4) != 0;
        inst.si.rs2_valid = rand_below(2) != 0;
        inst.si.rd_valid  = rand_below(4) != 0;
        inst.si.use_uimm  = rand_below(8) == 0;
        inst.id           = uop_pkg::rob_id_t'(m_tail);
        pick_source(inst.prs1_renamed, inst.prs1);
        pick_source(inst.prs2_renamed, inst.prs2);
        start = rand_below(NPREG);
        for (int k = 0; k < NPREG; k++) begin
            if (!prd_in_use(uop_pkg::preg_id_t'(start + k))) begin
                inst.prd = uop_pkg::preg_id_t'(start + k);
                break;
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [159:0] exp,
                                   input logic [159:0] act);
        errors++;
        $display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
    endtask

    task automatic run_cycle(input logic allow_new);
        int   s;
        int   mode;
        logic issue;
        @(negedge clk);
        wb           = '0;
        wb_valid     = '0;
        bypass       = '0;
        bypass_valid = '0;
        compl        = '0;
        // Completions first, so a result written this cycle waits one more
        for (int c = 0; c < core_cfg_pkg::NR_COMPL_PORTS; c++) begin
            s = find_slot(2'd2);
            if (s >= 0 && rand_below(2) == 0) begin
                compl[c].valid = 1'b1;
                compl[c].id    = uop_pkg::rob_id_t'(s);
                slot_state[s]  = 2'd3;
            end
        end
        // Mode 0 writeback only, mode 1 bypass only, modes 2 to 4 both
        for (int p = 0; p < core_cfg_pkg::NR_WB_PORTS; p++) begin
            s    = find_slot(2'd1);
            mode = rand_below(8);
            if (s >= 0 && mode < 5) begin
                bypass[p].pc    = m_rob[s].pc;
                bypass[p].id    = uop_pkg::rob_id_t'(s);
                bypass[p].prd   = m_rob[s].prd;
                bypass[p].rdval = slot_val[s];
                bypass_valid[p] = mode != 0;
                if (mode != 1) begin
                    wb[p]         = bypass[p];
                    wb_valid[p]   = 1'b1;
                    slot_state[s] = 2'd2;
                end
            end
        end
        for (int f = 0; f < core_cfg_pkg::NR_FUS; f++) begin
            fu_ready[f] = rand_below(8) != 0;
        end
        if (!holding && allow_new && rand_below(4) != 0) begin
            new_inst(di);
            holding   = 1'b1;
            stall_cnt = 0;
        end
        di_valid = holding;
        #2;
        predict_issue(exp_rs1, exp_rs2, exp_ready);
        exp_fu = '{pc: di.si.pc, id: di.id, prd: di.prd, rs1val: exp_rs1, rs2val: exp_rs2,
                   imm: di.si.imm, fu: di.si.fu, op: di.si.op};
        issue = di_valid && exp_ready;
        assert (di_ready === exp_ready)
            else report_mismatch("di_ready_o", exp_ready, di_ready);
        assert (fu_valid === issue)
            else report_mismatch("fu_valid_o", issue, fu_valid);
        if (issue) begin
            assert (fu_input.rs1val === exp_rs1)
                else report_mismatch("fu_input_o.rs1val", exp_rs1, fu_input.rs1val);
            assert (fu_input.rs2val === exp_rs2)
                else report_mismatch("fu_input_o.rs2val", exp_rs2, fu_input.rs2val);
            assert (fu_input === exp_fu)
                else report_mismatch("fu_input_o", exp_fu, fu_input);
        end
        assert (retire_valid === m_ret_valid)
            else report_mismatch("retire_valid_o", m_ret_valid, retire_valid);
        if (m_ret_valid) begin
            retired_cnt++;
            assert (retire === m_ret_entry)
                else report_mismatch("retire_o", m_ret_entry, retire);
        end
        @(posedge clk);
        if (issue) begin
            slot_state[m_tail] = 2'd1;
            slot_val[m_tail]   = $random(seed);
            last_prd           = di.prd;
            holding            = 1'b0;
            issued_cnt++;
        end else if (holding) begin
            stall_cnt++;
            if (stall_cnt > STALL_LIMIT) begin
                $display("instruction with ROB id %0d not accepted within %0d cycles",
                         di.id, STALL_LIMIT);
                timeouts++;
                aborted = 1'b1;
            end
        end
        model_step(issue);
    endtask

    function automatic logic core_busy();
        foreach (m_alloc[i]) begin
            if (m_alloc[i]) begin
                return 1'b1;
            end
        end
        return holding || m_ret_valid;
    endfunction

    initial begin
        rstn         = 1'b0;
        di           = '0;
        di_valid     = 1'b0;
        fu_ready     = '0;
        bypass       = '0;
        bypass_valid = '0;
        wb           = '0;
        wb_valid     = '0;
        compl        = '0;
        holding      = 1'b0;
        stall_cnt    = 0;
        last_prd     = '0;
        errors       = 0;
        timeouts     = 0;
        issued_cnt   = 0;
        retired_cnt  = 0;
        aborted      = 1'b0;
        foreach (slot_state[i]) begin
            slot_state[i] = 2'd0;
            slot_val[i]   = '0;
        end
        model_reset();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        for (int cyc = 0; cyc < NUM_CYCLES && !aborted; cyc++) begin
            run_cycle(1'b1);
        end
        // Drain the ROB with no new instructions
        for (int d = 0; !aborted && core_busy(); d++) begin
            if (d == DRAIN_LIMIT) begin
                $display("ROB did not drain within %0d cycles", DRAIN_LIMIT);
                timeouts++;
                aborted = 1'b1;
            end else begin
                run_cycle(1'b0);
            end
        end
        assert (retired_cnt > 0) else begin
            $display("no instruction retired during the run");
            errors++;
        end
        $display("issued %0d, retired %0d, errors %0d, timeouts %0d",
                 issued_cnt, retired_cnt, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
